// File: src/icache_pkg.sv
`default_nettype none

package icache_pkg;

  localparam int num_ways   = 4;
  localparam int num_sets   = 16;
  localparam int line_words = 16;

  typedef logic [21:0] tag_t;
  typedef logic [3:0]  index_t;
  typedef logic [3:0]  word_t;
  typedef logic [1:0]  way_t;
  typedef logic [1:0]  age_t;

  // One fetch address, seen by lookup and by refill
  typedef union packed {
    struct packed {
      tag_t        tag;
      index_t      index;
      word_t       word;
      logic [1:0]  byte_off;
    } lk;
    struct packed {
      logic [25:0] line;
      word_t       word;
      logic [1:0]  byte_off;
    } rf;
  } icache_addr_u;

endpackage

`default_nettype wire

// File: src/icache_if.sv
`default_nettype none

// Tag side between control and lookup
interface lookup_if;
  import icache_pkg::*;

  logic hit;
  way_t hit_way;
  way_t victim_way;
  logic touch;
  way_t touch_way;
  logic fill_done;
  way_t fill_way;

  modport lookup (
    output hit, hit_way, victim_way,
    input  touch, touch_way, fill_done, fill_way
  );
  modport ctrl (
    input  hit, hit_way, victim_way,
    output touch, touch_way, fill_done, fill_way
  );
endinterface

// Data side between control and data array
interface fill_if;
  import icache_pkg::*;

  logic        fill_we;
  way_t        fill_way;
  word_t       fill_word;
  logic [31:0] fill_data;
  logic        serve;
  way_t        serve_way;

  modport ctrl (output fill_we, fill_way, fill_word, fill_data, serve, serve_way);
  modport data (input  fill_we, fill_way, fill_word, fill_data, serve, serve_way);
endinterface

`default_nettype wire

// File: src/icache_lookup.sv
`default_nettype none

module icache_lookup (
  input  logic                     clk,
  input  logic                     rst,
  input  icache_pkg::icache_addr_u addr,
  lookup_if.lookup                 lk
);
  import icache_pkg::*;

  tag_t                  tag_q   [num_ways][num_sets];
  logic [num_sets-1:0]   valid_q [num_ways];
  age_t                  age_q   [num_ways][num_sets];
  index_t                idx;
  age_t                  set_age [num_ways];
  logic [num_ways-1:0]   set_valid;
  logic                  found;

  assign idx = addr.lk.index;

  ////////////////////////////////////////
  // Hit compare
  ////////////////////////////////////////
  always_comb
  begin
    lk.hit     = 1'b0;
    lk.hit_way = '0;
    for (int w = 0; w < num_ways; w++)
    begin
      set_age[w]   = age_q[w][idx];
      set_valid[w] = valid_q[w][idx];
      if (set_valid[w] && tag_q[w][idx] == addr.lk.tag && !lk.hit)
      begin
        lk.hit     = 1'b1;
        lk.hit_way = way_t'(w);
      end
    end
  end

  // First empty way, else oldest; lowest number wins ties
  always_comb
  begin
    found         = 1'b0;
    lk.victim_way = '0;
    for (int w = 0; w < num_ways; w++)
    begin
      if (!set_valid[w] && !found)
      begin
        found         = 1'b1;
        lk.victim_way = way_t'(w);
      end
    end
    if (!found)
    begin
      for (int w = 1; w < num_ways; w++)
      begin
        if (set_age[w] > set_age[lk.victim_way])
          lk.victim_way = way_t'(w);
      end
    end
  end

  ////////////////////////////////////////
  // Valid bits and ages
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < num_ways; w++)
      begin
        valid_q[w] <= '0;
        for (int s = 0; s < num_sets; s++)
          age_q[w][s] <= '0;
      end
    end
    else
    begin
      if (lk.fill_done)
        valid_q[lk.fill_way][idx] <= 1'b1;
      if (lk.touch)
      begin
        for (int w = 0; w < num_ways; w++)
        begin
          // Served way becomes youngest
          if (way_t'(w) == lk.touch_way)
            age_q[w][idx] <= '0;
          else if (set_age[w] <= set_age[lk.touch_way])
            age_q[w][idx] <= set_age[w] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (lk.fill_done)
      tag_q[lk.fill_way][idx] <= addr.lk.tag;
  end

endmodule

`default_nettype wire

// File: src/icache_refill.sv
`default_nettype none

module icache_refill (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req,
  input  icache_pkg::icache_addr_u addr,
  lookup_if.ctrl                   lk,
  fill_if.ctrl                     fl,
  output logic                     ok,
  output logic                     mem_req,
  output logic [31:0]              mem_addr,
  input  logic                     mem_ack,
  input  logic [31:0]              mem_data
);
  import icache_pkg::*;

  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_fetch  = 2'd1;
  localparam logic [1:0] st_finish = 2'd2;
  localparam logic [1:0] st_serve  = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;
  way_t       way_q;
  word_t      cnt_q;
  logic       hit_now;
  logic       start_fill;
  logic       last_word;

  assign hit_now    = state_q == st_idle && req && lk.hit;
  assign start_fill = state_q == st_idle && req && !lk.hit;
  assign last_word  = cnt_q == word_t'(line_words - 1);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:
        if (hit_now)
          state_d = st_serve;
        else if (start_fill)
          state_d = st_fetch;
      st_fetch:
        if (mem_ack && last_word)
          state_d = st_finish;
      st_finish: state_d = st_idle;
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q <= st_idle;
      way_q   <= '0;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (start_fill)
      begin
        way_q <= lk.victim_way;
        cnt_q <= '0;
      end
      else if (state_q == st_fetch && mem_ack)
        cnt_q <= cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Lookup, fill and port outputs
  ////////////////////////////////////////
  assign lk.touch     = hit_now;
  assign lk.touch_way = lk.hit_way;
  assign lk.fill_done = state_q == st_finish;
  assign lk.fill_way  = way_q;

  assign fl.serve     = hit_now;
  assign fl.serve_way = lk.hit_way;
  assign fl.fill_we   = state_q == st_fetch && mem_ack;
  assign fl.fill_way  = way_q;
  assign fl.fill_word = cnt_q;
  assign fl.fill_data = mem_data;

  assign ok       = state_q == st_serve;
  assign mem_req  = state_q == st_fetch;
  // Line base plus the running word count
  assign mem_addr = {addr.rf.line, cnt_q, 2'b00};

endmodule

`default_nettype wire

// File: src/icache_data.sv
`default_nettype none

module icache_data (
  input  logic                     clk,
  input  logic                     rst,
  input  icache_pkg::icache_addr_u addr,
  fill_if.data                     fl,
  output logic [31:0]              ins
);
  import icache_pkg::*;

  logic [31:0] line_q [num_ways][num_sets][line_words];
  index_t      idx;
  word_t       off;

  assign idx = addr.lk.index;
  assign off = addr.lk.word;

  // One refill word per acknowledge
  always_ff @(posedge clk)
  begin
    if (fl.fill_we)
      line_q[fl.fill_way][idx][fl.fill_word] <= fl.fill_data;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      ins <= '0;
    else if (fl.serve)
      ins <= line_q[fl.serve_way][idx][off];
  end

endmodule

`default_nettype wire

// File: src/icache_top.sv
`default_nettype none

module icache_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        req,
  input  logic [31:0] addr,
  output logic [31:0] ins,
  output logic        ok,
  output logic        mem_req,
  output logic [31:0] mem_addr,
  input  logic        mem_ack,
  input  logic [31:0] mem_data
);
  import icache_pkg::*;

  icache_addr_u fetch_addr;

  lookup_if lk_bus ();
  fill_if   fl_bus ();

  assign fetch_addr = addr;

  icache_lookup u_lookup (
    .clk  (clk),
    .rst  (rst),
    .addr (fetch_addr),
    .lk   (lk_bus.lookup)
  );

  icache_refill u_refill (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .addr     (fetch_addr),
    .lk       (lk_bus.ctrl),
    .fl       (fl_bus.ctrl),
    .ok       (ok),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_ack  (mem_ack),
    .mem_data (mem_data)
  );

  icache_data u_data (
    .clk  (clk),
    .rst  (rst),
    .addr (fetch_addr),
    .fl   (fl_bus.data),
    .ins  (ins)
  );

endmodule

`default_nettype wire

// File: verif/icache_assert.sv
`default_nettype none

module icache_assert (
  input logic        clk,
  input logic        rst,
  input logic        ok,
  input logic        mem_req,
  input logic [31:0] mem_addr,
  input logic        mem_ack
);
  int error_count = 0;

  // ok is a single-cycle pulse
  assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else begin error_count++; $error("ok held high for two cycles"); end

  assert property (@(posedge clk) disable iff (rst) !(ok && mem_req))
    else begin error_count++; $error("ok and mem_req high together"); end

  // Address holds until memory answers
  assert property (@(posedge clk) disable iff (rst) mem_req && !mem_ack |=> $stable(mem_addr))
    else begin error_count++; $error("mem_addr moved without mem_ack"); end

  assert property (@(posedge clk) $fell(rst) |-> !ok && !mem_req)
    else begin error_count++; $error("ok or mem_req high right after reset"); end

endmodule

bind icache_top icache_assert u_assert (
  .clk      (clk),
  .rst      (rst),
  .ok       (ok),
  .mem_req  (mem_req),
  .mem_addr (mem_addr),
  .mem_ack  (mem_ack)
);

`default_nettype wire

// File: verif/icache_checker.sv
`default_nettype none

module icache_checker #(
  parameter logic [31:0] pattern = 32'h0
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         req,
  input  logic [31:0]  addr,
  input  logic [31:0]  ins,
  input  logic         ok,
  input  logic         mem_req,
  input  logic [31:0]  mem_addr,
  input  logic         mem_ack,
  input  logic [127:0] test_name,
  input  int           exp_fetch,
  output int           pass_count,
  output int           fail_count
);
  int          acks = 0;
  logic        bad = 1'b0;
  logic [31:0] exp_addr;
  logic [31:0] exp_ins;

  initial
  begin
    pass_count = 0;
    fail_count = 0;
  end

  function automatic logic [31:0] expected_ins(input logic [31:0] a);
    return {2'b00, a[31:2]} ^ pattern;
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      acks = 0;
      bad  = 1'b0;
    end
    else
    begin
      // Refill must walk the line from word 0 up
      if (mem_req && mem_ack)
      begin
        exp_addr = {addr[31:6], acks[3:0], 2'b00};
        if (acks >= 16 || mem_addr !== exp_addr)
        begin
          $display("Fail %0s mem_addr: expected %h, actual %h", test_name, exp_addr, mem_addr);
          bad = 1'b1;
        end
        acks++;
      end
      if (ok && !req)
      begin
        $display("ok pulsed with no request pending");
        fail_count++;
      end
      else if (ok)
      begin
        exp_ins = expected_ins(addr);
        if (ins !== exp_ins)
        begin
          $display("Fail %0s ins: expected %h, actual %h", test_name, exp_ins, ins);
          bad = 1'b1;
        end
        if (acks != exp_fetch)
        begin
          $display("Fail %0s fetches: expected %0d, actual %0d", test_name, exp_fetch, acks);
          bad = 1'b1;
        end
        if (bad)
          fail_count++;
        else
        begin
          $display("Pass %0s: ins %h after %0d fetches", test_name, ins, acks);
          pass_count++;
        end
        acks = 0;
        bad  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/icache_tb.sv
`default_nettype none

module icache_tb;
  localparam logic [31:0] pattern = 32'h5A3C_96E1;

  logic         clk;
  logic         rst;
  logic         req;
  logic [31:0]  addr;
  logic [31:0]  ins;
  logic         ok;
  logic         mem_req;
  logic [31:0]  mem_addr;
  logic         mem_ack;
  logic [31:0]  mem_data;
  logic [127:0] cur_name;
  int           cur_fetch;
  int           pass_count;
  int           fail_count;

  logic [127:0] names [$];
  logic [31:0]  addrs [$];
  int           fetches [$];
  int           num_tests = 0;
  logic         loaded = 1'b0;
  logic         load_fail = 1'b0;
  int           fd;
  string        line;
  logic [127:0] nm;
  logic [31:0]  a;
  int           n;
  int           delay_left;

  icache_top DUT (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .addr     (addr),
    .ins      (ins),
    .ok       (ok),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_ack  (mem_ack),
    .mem_data (mem_data)
  );

  icache_checker #(.pattern(pattern)) u_checker (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .addr       (addr),
    .ins        (ins),
    .ok         (ok),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ack    (mem_ack),
    .test_name  (cur_name),
    .exp_fetch  (cur_fetch),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
    return {2'b00, byte_addr[31:2]} ^ pattern;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Memory model, random ack delay
  ////////////////////////////////////////
  initial
  begin
    void'($urandom(94));
    mem_ack    = 1'b0;
    mem_data   = '0;
    delay_left = $urandom % 4;
    forever
    begin
      @(negedge clk);
      mem_ack = 1'b0;
      if (mem_req)
      begin
        if (delay_left == 0)
        begin
          mem_ack    = 1'b1;
          mem_data   = mem_word(mem_addr);
          delay_left = $urandom % 4;
        end
        else
          delay_left = delay_left - 1;
      end
    end
  end

  // Watchdog sized from the test count
  initial
  begin
    wait (loaded && num_tests > 0);
    repeat (num_tests * 400) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", num_tests * 400);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial
  begin
    rst       = 1'b1;
    req       = 1'b0;
    addr      = '0;
    cur_name  = '0;
    cur_fetch = 0;
    fd = $fopen("verif/icache_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open test file verif/icache_tests.txt");
      load_fail = 1'b1;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#" && $sscanf(line, "%s %h %d", nm, a, n) == 3)
        begin
          names.push_back(nm);
          addrs.push_back(a);
          fetches.push_back(n);
        end
      end
      $fclose(fd);
    end
    num_tests = names.size();
    loaded    = 1'b1;

    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    foreach (names[i])
    begin
      cur_name  = names[i];
      cur_fetch = fetches[i];
      addr      = addrs[i];
      req       = 1'b1;
      do
        @(negedge clk);
      while (!ok);
      // Hold through the ok cycle so the checker sees it
      @(negedge clk);
      req = 1'b0;
      // One idle cycle between requests
      @(negedge clk);
    end
    @(negedge clk);

    $display("Tests: %0d run, %0d passed, %0d failed, %0d assertion errors",
             num_tests, pass_count, fail_count, DUT.u_assert.error_count);
    if (load_fail || num_tests == 0 || fail_count != 0 || pass_count != num_tests ||
        DUT.u_assert.error_count != 0)
      $display("Result: FAILED");
    else
      $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/icache_pkg.sv
src/icache_if.sv
src/icache_lookup.sv
src/icache_refill.sv
src/icache_data.sv
src/icache_top.sv
verif/icache_assert.sv
verif/icache_checker.sv
verif/icache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/icache_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "Simulation log holds no result line"
  exit 1
fi
exit 0

// File: verif/icache_tests.txt
# name  fetch address (hex)  expected memory fetches
# Set 3 is shared by tags 4, 8, 12, 16 and 20
cold_a     000010C4 16
same_a0    000010C0 0
same_a15   000010FC 0
same_a7    000010DC 0
fill_b     000020C8 16
fill_c     000030CC 16
fill_d     000040D0 16
hit_b      000020D4 0
hit_a      000010E0 0
hit_c      000030F0 0
hit_d      000040C4 0
evict_e    000050C0 16
still_a    000010C8 0
still_c    000030C4 0
still_d    000040FC 0
refetch_b  000020C0 16
